// ==== bench/clock_gen.sv ====
// ======================================================================
// Testbench clock and reset source, free-running clock and a reset
// held low for a fixed number of cycles
// ======================================================================
`timescale 1ns/1ns

module clock_gen #(
	parameter int period_ns    = 100,
	parameter int reset_cycles = 16
) (
	output logic clk,
	output logic arst_n
);

	initial
	begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

	// Reset drops at time 0 and rises a little after a rising edge
	initial
	begin
		arst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#(period_ns / 10);
		arst_n = 1'b1;
	end

endmodule

// ==== bench/tb_alu_cluster.sv ====
// ======================================================================
// Directed testbench for the two-lane ALU cluster that issues operations
// and checks the results against a reference model
// ======================================================================
`timescale 1ns/1ns

module tb_alu_cluster;

	import alu_pkg::*;

	localparam int timeout_cycles = 100;

	logic        clk;
	logic        arst_n;
	alu_issue_t  issue0;
	alu_issue_t  issue1;
	logic        busy0;
	logic        busy1;
	alu_result_t result0;
	alu_result_t result1;

	logic [31:0] lfsr_state;
	tag_t        next_tag;
	int          checks;
	int          errors;
	int          mark_checks;
	int          mark_errors;
	bit          aborted;

	clock_gen #(.period_ns(100), .reset_cycles(16)) u_clock (
		.clk    (clk),
		.arst_n (arst_n)
	);

	alu_cluster dut0 (
		.clk     (clk),
		.arst_n  (arst_n),
		.issue0  (issue0),
		.issue1  (issue1),
		.busy0   (busy0),
		.busy1   (busy1),
		.result0 (result0),
		.result1 (result1)
	);

	// ==================================================================
	// Stimulus helpers
	// ==================================================================

	// Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken
	function automatic value_t random_bits(input int n);
		value_t v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic instruction_t make_r2(input opcode_t op, input func_t fn);
		instruction_t ir;
		ir.r2.opcode = op;
		ir.r2.func   = fn;
		ir.r2.spare  = '0;
		return ir;
	endfunction

	function automatic instruction_t make_shift(input func_t fn, input logic imm,
		input logic [4:0] amt);
		instruction_t ir;
		ir.shift.opcode  = op_shift;
		ir.shift.func    = fn;
		ir.shift.imm_sel = imm;
		ir.shift.amount  = amt;
		ir.shift.spare   = '0;
		return ir;
	endfunction

	// ==================================================================
	// Reference model
	// ==================================================================

	// Bit 0 equal, bit 1 less, bit 2 greater
	function automatic value_t compare_word(input bit eq, input bit lt);
		return {29'd0, !eq && !lt, lt, eq};
	endfunction

	function automatic value_t divide_model(input value_t a, input value_t b,
		input bit sgn, input bit want_rem);
		longint sa;
		longint sb;
		longint q;
		longint r;
		// Divide by zero gives all ones and keeps the dividend as remainder
		if (b == '0)
			return want_rem ? a : 32'hffff_ffff;
		if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff)
			return want_rem ? 32'h0 : a;
		if (sgn)
		begin
			sa = $signed(a);
			sb = $signed(b);
		end
		else
		begin
			sa = {32'd0, a};
			sb = {32'd0, b};
		end
		// Division truncates toward zero and the remainder follows the dividend's sign
		q = sa / sb;
		r = sa % sb;
		return want_rem ? r[31:0] : q[31:0];
	endfunction

	function automatic value_t model_value(input instruction_t ir, input value_t a,
		input value_t b, input bit has_div);
		logic signed [63:0] ps;
		logic [63:0]        pu;
		int                 amt;
		value_t             res;
		ps  = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
		pu  = {32'd0, a} * {32'd0, b};
		amt = ir.shift.imm_sel ? int'(ir.shift.amount) : int'(b[4:0]);
		case (ir.r2.opcode)
			op_r2:
				case (ir.r2.func)
					fn_add:   res = a + b;
					fn_sub:   res = a - b;
					fn_and:   res = a & b;
					fn_or:    res = a | b;
					fn_xor:   res = a ^ b;
					fn_nor:   res = ~(a | b);
					fn_cmp:   res = compare_word(a == b, $signed(a) < $signed(b));
					fn_cmpu:  res = compare_word(a == b, a < b);
					fn_slt:   res = {31'd0, $signed(a) < $signed(b)};
					fn_sltu:  res = {31'd0, a < b};
					fn_seq:   res = {31'd0, a == b};
					fn_mul:   res = ps[31:0];
					fn_mulu:  res = pu[31:0];
					fn_mulh:  res = ps[63:32];
					fn_muluh: res = pu[63:32];
					fn_div:   res = has_div ? divide_model(a, b, 1'b1, 1'b0) : '0;
					fn_divu:  res = has_div ? divide_model(a, b, 1'b0, 1'b0) : '0;
					fn_mod:   res = has_div ? divide_model(a, b, 1'b1, 1'b1) : '0;
					fn_modu:  res = has_div ? divide_model(a, b, 1'b0, 1'b1) : '0;
					default:  res = 32'hdeadbeef;
				endcase
			op_shift:
				case (ir.shift.func)
					fn_asl:  res = a << amt;
					fn_lsr:  res = a >> amt;
					fn_asr:  res = $signed(a) >>> amt;
					// A shift by the full width gives zero, so amount 0 is a plain copy
					fn_rol:  res = (a << amt) | (a >> (32 - amt));
					fn_ror:  res = (a >> amt) | (a << (32 - amt));
					default: res = 32'hdeadbeef;
				endcase
			op_addi: res = a + b;
			op_andi: res = a & b;
			op_ori:  res = a | b;
			op_xori: res = a ^ b;
			op_muli: res = ps[31:0];
			op_divi: res = has_div ? divide_model(a, b, 1'b1, 1'b0) : '0;
			op_mov:  res = a;
			op_nop:  res = '0;
			default: res = 32'hdeadbeef;
		endcase
		return res;
	endfunction

	// Only a real divider flags a zero divisor
	function automatic logic model_dbz(input instruction_t ir, input value_t b,
		input bit has_div);
		logic is_div;
		is_div = (ir.r2.opcode == op_divi) || (ir.r2.opcode == op_r2 &&
			ir.r2.func inside {fn_div, fn_divu, fn_mod, fn_modu});
		return has_div && is_div && b == '0;
	endfunction

	// ==================================================================
	// Compare tasks and reporting
	// ==================================================================
	task automatic check_result(input string name, input alu_result_t got,
		input tag_t exp_tag, input value_t exp_value);
		checks++;
		if (got.tag !== exp_tag)
		begin
			errors++;
			$display("Mismatch %s.tag: got 0x%h expected 0x%h", name, got.tag, exp_tag);
		end
		if (got.value !== exp_value)
		begin
			errors++;
			$display("Mismatch %s.value: got 0x%h expected 0x%h", name, got.value, exp_value);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic report_test(input string name);
		$display("%s finished: %0d checks, %0d errors", name, checks - mark_checks,
			errors - mark_errors);
		mark_checks = checks;
		mark_errors = errors;
	endtask

	// ==================================================================
	// Issue and wait
	// ==================================================================
	task automatic drive_issue(input int lane, input alu_issue_t op);
		@(posedge clk);
		#10;
		if (lane == 0)
			issue0 = op;
		else
			issue1 = op;
	endtask

	// Counts edges from the issue until a valid result and ends each strobe after one edge
	// Busy is also sampled just after the edge that takes the issue
	task automatic wait_result(input int lane, output alu_result_t got, output int cycles,
		output logic busy_after);
		bit seen;
		seen       = 1'b0;
		cycles     = 0;
		got        = '0;
		busy_after = 1'b0;
		while (!seen && cycles < timeout_cycles)
		begin
			@(posedge clk);
			cycles++;
			#1;
			if (cycles == 1)
				busy_after = (lane == 0) ? busy0 : busy1;
			got  = (lane == 0) ? result0 : result1;
			seen = got.valid;
			#9;
			issue0.valid = 1'b0;
			issue1.valid = 1'b0;
		end
		if (!seen)
		begin
			errors++;
			aborted = 1'b1;
			$display("Timeout: no result on lane %0d within %0d cycles", lane, timeout_cycles);
		end
	endtask

	// A latency of 0 means the operation takes a variable number of cycles
	task automatic run_op(input int lane, input instruction_t ir, input value_t a,
		input value_t b, input int exp_latency);
		alu_issue_t  op;
		alu_result_t got;
		int          cycles;
		logic        busy_after;
		tag_t        tag;
		string       name;
		string       busy_name;
		if (aborted)
			return;
		tag = next_tag;
		next_tag++;
		op = '{valid: 1'b1, tag: tag, ir: ir, a: a, b: b};
		drive_issue(lane, op);
		wait_result(lane, got, cycles, busy_after);
		if (aborted)
			return;
		name      = (lane == 0) ? "result0" : "result1";
		busy_name = (lane == 0) ? "busy0" : "busy1";
		check_result(name, got, tag, model_value(ir, a, b, lane == 0));
		check_flag({name, ".dbz"}, got.dbz, model_dbz(ir, b, lane == 0));
		// Multiply and divide hold the lane busy, single-cycle work never does
		check_flag(busy_name, busy_after, exp_latency != 1);
		if (exp_latency > 0 && cycles != exp_latency)
		begin
			errors++;
			$display("Wrong latency on lane %0d: result after %0d cycles, expected %0d",
				lane, cycles, exp_latency);
		end
	endtask

	// ==================================================================
	// Directed tests
	// ==================================================================
	task automatic reset_and_arith();
		func_t   fns [6];
		opcode_t imms [4];
		int      cycles;
		fns  = '{fn_add, fn_sub, fn_and, fn_or, fn_xor, fn_nor};
		imms = '{op_addi, op_andi, op_ori, op_xori};
		cycles = 0;
		while (!arst_n && cycles < 40)
		begin
			@(posedge clk);
			cycles++;
			#1;
		end
		if (!arst_n)
		begin
			errors++;
			aborted = 1'b1;
			$display("Reset was never released");
		end
		check_flag("result0.valid", result0.valid, 1'b0);
		check_flag("result1.valid", result1.valid, 1'b0);
		check_flag("busy0", busy0, 1'b0);
		check_flag("busy1", busy1, 1'b0);
		for (int lane = 0; lane < 2; lane++)
		begin
			for (int i = 0; i < 6; i++)
				run_op(lane, make_r2(op_r2, fns[i]), random_bits(32), random_bits(32), 1);
			for (int i = 0; i < 4; i++)
				run_op(lane, make_r2(imms[i], fn_add), random_bits(32), random_bits(16), 1);
			run_op(lane, make_r2(op_mov, fn_add), random_bits(32), random_bits(32), 1);
			run_op(lane, make_r2(op_nop, fn_add), random_bits(32), random_bits(32), 1);
			// Codes outside the decode tables
			run_op(lane, make_r2(opcode_t'(6'h3e), fn_add), random_bits(32), random_bits(32), 1);
			run_op(lane, make_r2(op_r2, func_t'(6'h3d)), random_bits(32), random_bits(32), 1);
		end
		report_test("reset_arith");
	endtask

	task automatic compare_ops();
		func_t  fns [5];
		value_t x;
		value_t y;
		fns = '{fn_cmp, fn_cmpu, fn_slt, fn_sltu, fn_seq};
		for (int pair = 0; pair < 6; pair++)
		begin
			x = random_bits(32);
			// Equal pairs, pairs that differ only in the sign bit, then random pairs
			case (pair)
				0, 1:    y = x;
				2, 3:    y = x ^ 32'h8000_0000;
				default: y = random_bits(32);
			endcase
			for (int i = 0; i < 5; i++)
			begin
				run_op(pair % 2, make_r2(op_r2, fns[i]), x, y, 1);
				run_op(pair % 2, make_r2(op_r2, fns[i]), y, x, 1);
			end
		end
		report_test("compare");
	endtask

	task automatic shift_ops();
		func_t      fns [5];
		logic [4:0] amounts [4];
		value_t     b;
		fns     = '{fn_asl, fn_lsr, fn_asr, fn_rol, fn_ror};
		amounts = '{5'd0, 5'd31, 5'd0, 5'd0};
		amounts[2] = 5'(random_bits(5));
		amounts[3] = 5'(random_bits(5));
		for (int i = 0; i < 5; i++)
		begin
			for (int k = 0; k < 4; k++)
			begin
				// Immediate form with noise in b that must be ignored
				run_op(k % 2, make_shift(fns[i], 1'b1, amounts[k]), random_bits(32),
					random_bits(32), 1);
				// Register form with noise in the immediate field instead
				b = random_bits(32);
				b[4:0] = amounts[k];
				run_op(k % 2, make_shift(fns[i], 1'b0, 5'(random_bits(5))), random_bits(32),
					b, 1);
			end
		end
		report_test("shift");
	endtask

	task automatic multiply_ops();
		func_t       fns [4];
		value_t      ea [4];
		value_t      eb [4];
		alu_issue_t  op;
		alu_result_t got;
		int          cycles;
		logic        busy_after;
		int          extra;
		tag_t        mul_tag;
		value_t      a;
		value_t      b;
		fns = '{fn_mul, fn_mulu, fn_mulh, fn_muluh};
		ea  = '{32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff, 32'h0000_0001};
		eb  = '{32'hffff_ffff, 32'hffff_ffff, 32'h8000_0000, 32'h8000_0000};
		for (int lane = 0; lane < 2; lane++)
		begin
			for (int i = 0; i < 4; i++)
			begin
				for (int k = 0; k < 3; k++)
					run_op(lane, make_r2(op_r2, fns[i]), random_bits(32), random_bits(32), 4);
				for (int k = 0; k < 4; k++)
					run_op(lane, make_r2(op_r2, fns[i]), ea[k], eb[k], 4);
			end
			run_op(lane, make_r2(op_muli, fn_add), random_bits(32), random_bits(12), 4);
		end
		// An add issued one cycle into a multiply must vanish
		if (!aborted)
		begin
			a = random_bits(32);
			b = random_bits(32);
			mul_tag = next_tag;
			next_tag++;
			op = '{valid: 1'b1, tag: mul_tag, ir: make_r2(op_r2, fn_mulh), a: a, b: b};
			drive_issue(1, op);
			op = '{valid: 1'b1, tag: next_tag, ir: make_r2(op_r2, fn_add), a: b, b: a};
			next_tag++;
			drive_issue(1, op);
			check_flag("busy1", busy1, 1'b1);
			wait_result(1, got, cycles, busy_after);
			if (!aborted)
			begin
				check_flag("busy1", busy_after, 1'b1);
				check_result("result1", got, mul_tag,
					model_value(make_r2(op_r2, fn_mulh), a, b, 1'b0));
				extra = 0;
				for (int i = 0; i < 6; i++)
				begin
					@(posedge clk);
					#1;
					if (result1.valid)
						extra++;
				end
				if (extra != 0)
				begin
					errors++;
					$display("An issue dropped while lane 1 was busy still produced a result");
				end
				check_flag("busy1", busy1, 1'b0);
			end
		end
		report_test("multiply");
	endtask

	task automatic divide_ops();
		func_t  fns [4];
		value_t b;
		fns = '{fn_div, fn_divu, fn_mod, fn_modu};
		for (int i = 0; i < 4; i++)
		begin
			for (int k = 0; k < 4; k++)
			begin
				// Wide divisors first, then small positive and small negative ones
				if (k < 2)
					b = random_bits(32);
				else
					b = random_bits(8) + 32'd1;
				if (k == 3)
					b = '0 - b;
				run_op(0, make_r2(op_r2, fns[i]), random_bits(32), b, 0);
			end
			run_op(0, make_r2(op_r2, fns[i]), random_bits(32), 32'h0, 0);
			run_op(0, make_r2(op_r2, fns[i]), 32'h8000_0000, 32'hffff_ffff, 0);
		end
		run_op(0, make_r2(op_divi, fn_add), random_bits(32), random_bits(8) + 32'd1, 0);
		run_op(0, make_r2(op_divi, fn_add), random_bits(32), 32'h0, 0);
		// Lane 1 has no divider and answers zero at once
		for (int i = 0; i < 4; i++)
			run_op(1, make_r2(op_r2, fns[i]), random_bits(32), random_bits(32), 1);
		run_op(1, make_r2(op_divi, fn_add), random_bits(32), 32'h0, 1);
		report_test("divide");
	endtask

	// ==================================================================
	// Main sequence
	// ==================================================================
	initial
	begin
		issue0      = '0;
		issue1      = '0;
		lfsr_state  = 32'hcd8f_d0a0;
		next_tag    = '0;
		checks      = 0;
		errors      = 0;
		mark_checks = 0;
		mark_errors = 0;
		aborted     = 1'b0;

		reset_and_arith();
		compare_ops();
		shift_ops();
		multiply_ops();
		divide_ops();

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// ==== build.f ====
logic/alu_pkg.sv
logic/alu_compare.sv
logic/alu_shifter.sv
logic/alu_multiplier.sv
logic/alu_divider.sv
logic/alu_lane.sv
logic/alu_cluster.sv
bench/clock_gen.sv
bench/tb_alu_cluster.sv

// ==== logic/alu_cluster.sv ====
// ======================================================================
// Integer execution cluster, lane 0 with the divider and lane 1 without
// ======================================================================
`timescale 1ns/1ns

module alu_cluster (
	input  logic                 clk,
	input  logic                 arst_n,
	input  alu_pkg::alu_issue_t  issue0,
	input  alu_pkg::alu_issue_t  issue1,
	output logic                 busy0,
	output logic                 busy1,
	output alu_pkg::alu_result_t result0,
	output alu_pkg::alu_result_t result1
);

	alu_lane #(.has_divider(1'b1)) lane0 (
		.clk    (clk),
		.arst_n (arst_n),
		.issue  (issue0),
		.busy   (busy0),
		.result (result0)
	);

	// Lane 1 answers divides with zero in one cycle
	alu_lane #(.has_divider(1'b0)) lane1 (
		.clk    (clk),
		.arst_n (arst_n),
		.issue  (issue1),
		.busy   (busy1),
		.result (result1)
	);

endmodule

// ==== logic/alu_compare.sv ====
// ======================================================================
// Compare unit, gives the flags for set-if and the two compare words
// ======================================================================
`timescale 1ns/1ns

module alu_compare (
	input  alu_pkg::value_t     a,
	input  alu_pkg::value_t     b,
	output alu_pkg::cmp_flags_t flags,
	output alu_pkg::value_t     cmp_word,
	output alu_pkg::value_t     cmpu_word
);

	// Each relation is computed once and shared by all users
	assign flags.eq  = (a == b);
	assign flags.lt  = ($signed(a) < $signed(b));
	assign flags.ltu = (a < b);

	// Word layout is bit 2 greater, bit 1 less, bit 0 equal
	assign cmp_word  = {29'd0, ~flags.eq & ~flags.lt, flags.lt, flags.eq};
	assign cmpu_word = {29'd0, ~flags.eq & ~flags.ltu, flags.ltu, flags.eq};

endmodule

// ==== logic/alu_divider.sv ====
// ======================================================================
// Restoring radix-2 divider, one load cycle then 32 iterations
// ======================================================================
`timescale 1ns/1ns

module alu_divider (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            start,
	input  logic            signed_mode,
	input  alu_pkg::value_t a,
	input  alu_pkg::value_t b,
	output logic            done,
	output alu_pkg::value_t quotient,
	output alu_pkg::value_t remainder,
	output logic            dbz
);

	import alu_pkg::*;

	logic        running;
	logic [5:0]  count;
	logic        neg_a;
	logic        neg_b;
	value_t      quo;
	value_t      rem;
	value_t      dvs;
	value_t      dividend;
	logic        neg_q;
	logic        neg_r;
	logic        dbz_r;
	logic        ovf_r;
	logic [32:0] partial;
	value_t      q_fix;
	value_t      r_fix;

	assign neg_a = signed_mode & a[31];
	assign neg_b = signed_mode & b[31];

	// Next partial remainder with the top quotient bit brought down
	assign partial = {rem, quo[31]};

	// ==================================================================
	// Sequencer
	// ==================================================================
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			running <= 1'b0;
			count   <= '0;
			done    <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (start)
			begin
				running <= 1'b1;
				count   <= 6'd32;
			end
			else if (running)
			begin
				count <= count - 6'd1;
				// Last iteration, done pulses for one cycle after it
				if (count == 6'd1)
				begin
					running <= 1'b0;
					done    <= 1'b1;
				end
			end
		end
	end

	// ==================================================================
	// Datapath on magnitudes
	// ==================================================================
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			quo      <= neg_a ? -a : a;
			dvs      <= neg_b ? -b : b;
			rem      <= '0;
			dividend <= a;
			neg_q    <= neg_a ^ neg_b;
			neg_r    <= neg_a;
			dbz_r    <= (b == '0);
			ovf_r    <= signed_mode && a == 32'h8000_0000 && b == 32'hffff_ffff;
		end
		else if (running)
		begin
			// Subtract only when the divisor fits, else keep the shifted value
			if (partial >= {1'b0, dvs})
			begin
				rem <= partial[31:0] - dvs;
				quo <= {quo[30:0], 1'b1};
			end
			else
			begin
				rem <= partial[31:0];
				quo <= {quo[30:0], 1'b0};
			end
		end
	end

	// Remainder takes the sign of the dividend
	assign q_fix = neg_q ? -quo : quo;
	assign r_fix = neg_r ? -rem : rem;

	always_comb
	begin
		if (dbz_r)
		begin
			quotient  = '1;
			remainder = dividend;
		end
		else if (ovf_r)
		begin
			quotient  = dividend;
			remainder = '0;
		end
		else
		begin
			quotient  = q_fix;
			remainder = r_fix;
		end
	end

	assign dbz = dbz_r;

	a_no_restart: assert property (@(posedge clk) disable iff (!arst_n)
		start |-> !running);

endmodule

// ==== logic/alu_lane.sv ====
// ======================================================================
// One ALU lane: decodes an issued operation, runs it and returns a
// tagged result, with multiply and optional divide on their own units
// ======================================================================
`timescale 1ns/1ns

module alu_lane #(
	parameter bit has_divider = 1'b1
) (
	input  logic                clk,
	input  logic                arst_n,
	input  alu_pkg::alu_issue_t issue,
	output logic                busy,
	output alu_pkg::alu_result_t result
);

	import alu_pkg::*;

	instruction_t ir;
	value_t       a;
	value_t       b;
	logic         accept;
	logic         is_r2;
	logic         is_mul;
	logic         is_div;
	logic         want_rem;
	cmp_flags_t   flags;
	value_t       cmp_word;
	value_t       cmpu_word;
	value_t       shift_value;
	value_t       single_value;
	logic         mul_done;
	tag_t         mul_tag;
	value_t       mul_product;
	logic         div_done;
	value_t       div_q;
	value_t       div_r;
	logic         div_dbz;
	tag_t         pend_tag;
	logic         pend_rem;
	logic         res_valid;
	tag_t         res_tag;
	value_t       res_value;
	logic         res_dbz;

	assign ir = issue.ir;
	assign a  = issue.a;
	assign b  = issue.b;

	// No back-pressure, a strobe seen while busy is dropped
	assign accept = issue.valid & ~busy;

	// ==================================================================
	// Decode
	// ==================================================================
	assign is_r2  = (ir.r2.opcode == op_r2);
	assign is_mul = (ir.r2.opcode == op_muli) ||
		(is_r2 && ir.r2.func inside {fn_mul, fn_mulu, fn_mulh, fn_muluh});
	// Without a divider the divide forms fall through as single-cycle zeros
	assign is_div = has_divider && ((ir.r2.opcode == op_divi) ||
		(is_r2 && ir.r2.func inside {fn_div, fn_divu, fn_mod, fn_modu}));
	assign want_rem = is_r2 && ir.r2.func inside {fn_mod, fn_modu};

	alu_compare u_compare (
		.a         (a),
		.b         (b),
		.flags     (flags),
		.cmp_word  (cmp_word),
		.cmpu_word (cmpu_word)
	);

	alu_shifter u_shifter (
		.ir    (ir),
		.a     (a),
		.b     (b),
		.value (shift_value)
	);

	alu_multiplier u_multiplier (
		.clk         (clk),
		.arst_n      (arst_n),
		.start       (accept & is_mul),
		.signed_mode ((ir.r2.opcode == op_muli) || (is_r2 && ir.r2.func inside {fn_mul, fn_mulh})),
		.high_sel    (is_r2 && ir.r2.func inside {fn_mulh, fn_muluh}),
		.tag_in      (issue.tag),
		.a           (a),
		.b           (b),
		.done        (mul_done),
		.tag_out     (mul_tag),
		.product     (mul_product)
	);

	generate
		if (has_divider)
		begin : g_div
			logic div_start;
			logic div_signed;

			assign div_start  = accept & is_div;
			assign div_signed = (ir.r2.opcode == op_divi) ||
				(is_r2 && ir.r2.func inside {fn_div, fn_mod});

			alu_divider u_divider (
				.clk         (clk),
				.arst_n      (arst_n),
				.start       (div_start),
				.signed_mode (div_signed),
				.a           (a),
				.b           (b),
				.done        (div_done),
				.quotient    (div_q),
				.remainder   (div_r),
				.dbz         (div_dbz)
			);
		end
		else
		begin : g_no_div
			assign div_done = 1'b0;
			assign div_q    = '0;
			assign div_r    = '0;
			assign div_dbz  = 1'b0;
		end
	endgenerate

	// ==================================================================
	// Single-cycle result selector
	// ==================================================================
	always_comb
	begin
		case (ir.r2.opcode)
			op_r2:
				case (ir.r2.func)
					fn_add:  single_value = a + b;
					fn_sub:  single_value = a - b;
					fn_and:  single_value = a & b;
					fn_or:   single_value = a | b;
					fn_xor:  single_value = a ^ b;
					fn_nor:  single_value = ~(a | b);
					fn_cmp:  single_value = cmp_word;
					fn_cmpu: single_value = cmpu_word;
					fn_slt:  single_value = {31'd0, flags.lt};
					fn_sltu: single_value = {31'd0, flags.ltu};
					fn_seq:  single_value = {31'd0, flags.eq};
					// Unit operations, zero here is the lane 1 divide answer
					fn_mul, fn_mulu, fn_mulh, fn_muluh,
					fn_div, fn_divu, fn_mod, fn_modu:
						single_value = '0;
					default: single_value = 32'hdeadbeef;
				endcase
			op_shift: single_value = shift_value;
			op_addi:  single_value = a + b;
			op_andi:  single_value = a & b;
			op_ori:   single_value = a | b;
			op_xori:  single_value = a ^ b;
			op_muli,
			op_divi:  single_value = '0;
			op_mov:   single_value = a;
			op_nop:   single_value = '0;
			default:  single_value = 32'hdeadbeef;
		endcase
	end

	// ==================================================================
	// Control and result registers
	// ==================================================================
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			busy      <= 1'b0;
			res_valid <= 1'b0;
		end
		else
		begin
			// Busy spans the whole unit operation and drops with its result
			if (accept && (is_mul || is_div))
				busy <= 1'b1;
			else if (mul_done || div_done)
				busy <= 1'b0;
			res_valid <= (accept && !is_mul && !is_div) || mul_done || div_done;
		end
	end

	// Divide keeps its tag and quotient or remainder choice here
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			pend_tag <= issue.tag;
			pend_rem <= want_rem;
		end
	end

	always_ff @(posedge clk)
	begin
		if (mul_done)
		begin
			res_tag   <= mul_tag;
			res_value <= mul_product;
			res_dbz   <= 1'b0;
		end
		else if (div_done)
		begin
			res_tag   <= pend_tag;
			res_value <= pend_rem ? div_r : div_q;
			res_dbz   <= div_dbz;
		end
		else
		begin
			res_tag   <= issue.tag;
			res_value <= single_value;
			res_dbz   <= 1'b0;
		end
	end

	assign result = '{valid: res_valid, tag: res_tag, value: res_value, dbz: res_dbz};

	// The single result port is never claimed twice in one cycle
	a_one_result: assert property (@(posedge clk) disable iff (!arst_n)
		(accept && !is_mul && !is_div) |-> !(mul_done || div_done));

endmodule

// ==== logic/alu_multiplier.sv ====
// ======================================================================
// Three-stage 32x32 multiplier, signed or unsigned, high or low half out
// ======================================================================
`timescale 1ns/1ns

module alu_multiplier (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            start,
	input  logic            signed_mode,
	input  logic            high_sel,
	input  alu_pkg::tag_t   tag_in,
	input  alu_pkg::value_t a,
	input  alu_pkg::value_t b,
	output logic            done,
	output alu_pkg::tag_t   tag_out,
	output alu_pkg::value_t product
);

	import alu_pkg::*;

	logic signed [32:0] ext_a;
	logic signed [32:0] ext_b;
	logic signed [63:0] full;
	logic [2:0]         stage_valid;
	logic [2:0]         stage_high;
	tag_t               stage_tag [3];
	logic [63:0]        stage_prod [3];

	// A 33-bit signed view covers both modes with one multiplier
	assign ext_a = {signed_mode & a[31], a};
	assign ext_b = {signed_mode & b[31], b};
	assign full  = ext_a * ext_b;

	// Valid bits walk down the pipe beside the data
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			stage_valid <= '0;
		else
			stage_valid <= {stage_valid[1:0], start};
	end

	always_ff @(posedge clk)
	begin
		stage_prod[0] <= full;
		stage_tag[0]  <= tag_in;
		stage_high[0] <= high_sel;
		for (int i = 1; i < 3; i++)
		begin
			stage_prod[i] <= stage_prod[i-1];
			stage_tag[i]  <= stage_tag[i-1];
			stage_high[i] <= stage_high[i-1];
		end
	end

	assign done    = stage_valid[2];
	assign tag_out = stage_tag[2];
	assign product = stage_high[2] ? stage_prod[2][63:32] : stage_prod[2][31:0];

	// The lane keeps at most one product in flight
	a_single_item: assert property (@(posedge clk) disable iff (!arst_n)
		start |-> stage_valid == 3'b000);

endmodule

// ==== logic/alu_pkg.sv ====
// ======================================================================
// Shared types for the integer execution cluster: opcodes, function
// codes, the instruction word and the issue and result records
// ======================================================================
package alu_pkg;

	// One data word and the issuer's tag that follows it
	typedef logic [31:0] value_t;
	typedef logic [3:0]  tag_t;

	// Major opcodes
	typedef enum logic [5:0] {
		op_r2    = 6'h02,
		op_shift = 6'h03,
		op_addi  = 6'h04,
		op_muli  = 6'h06,
		op_divi  = 6'h07,
		op_andi  = 6'h08,
		op_ori   = 6'h09,
		op_xori  = 6'h0a,
		op_mov   = 6'h10,
		op_nop   = 6'h3f
	} opcode_t;

	// Function codes, register group first and shift group above 6'h20
	typedef enum logic [5:0] {
		fn_add   = 6'h04,
		fn_sub   = 6'h05,
		fn_and   = 6'h08,
		fn_or    = 6'h09,
		fn_xor   = 6'h0a,
		fn_nor   = 6'h0c,
		fn_cmp   = 6'h10,
		fn_cmpu  = 6'h11,
		fn_slt   = 6'h12,
		fn_sltu  = 6'h13,
		fn_seq   = 6'h14,
		fn_mul   = 6'h18,
		fn_mulu  = 6'h19,
		fn_mulh  = 6'h1a,
		fn_muluh = 6'h1b,
		fn_div   = 6'h1c,
		fn_divu  = 6'h1d,
		fn_mod   = 6'h1e,
		fn_modu  = 6'h1f,
		fn_asl   = 6'h20,
		fn_lsr   = 6'h21,
		fn_asr   = 6'h22,
		fn_rol   = 6'h23,
		fn_ror   = 6'h24
	} func_t;

	// Register form of the instruction word
	typedef struct packed {
		opcode_t     opcode;
		func_t       func;
		logic [19:0] spare;
	} instr_r2_t;

	// Shift form, opcode and func sit where the register form has them
	typedef struct packed {
		opcode_t     opcode;
		func_t       func;
		logic        imm_sel;
		logic [4:0]  amount;
		logic [13:0] spare;
	} instr_shift_t;

	typedef union packed {
		instr_r2_t    r2;
		instr_shift_t shift;
	} instruction_t;

	// One operation as it leaves the issue stage
	typedef struct packed {
		logic         valid;
		tag_t         tag;
		instruction_t ir;
		value_t       a;
		value_t       b;
	} alu_issue_t;

	// One completed operation
	typedef struct packed {
		logic   valid;
		tag_t   tag;
		value_t value;
		logic   dbz;
	} alu_result_t;

	typedef struct packed {
		logic eq;
		logic lt;
		logic ltu;
	} cmp_flags_t;

endpackage

// ==== logic/alu_shifter.sv ====
// ======================================================================
// Barrel shifter for the shift opcode group, register or immediate amount
// ======================================================================
`timescale 1ns/1ns

module alu_shifter (
	input  alu_pkg::instruction_t ir,
	input  alu_pkg::value_t       a,
	input  alu_pkg::value_t       b,
	output alu_pkg::value_t       value
);

	import alu_pkg::*;

	logic [4:0]  amt;
	logic [63:0] shl;
	logic [63:0] shr;
	value_t      asr;

	// Immediate amount when the instruction asks for it, else b
	assign amt = ir.shift.imm_sel ? ir.shift.amount : b[4:0];

	// Double-width shifts, the bits pushed out land in the other half
	assign shl = {32'd0, a} << amt;
	assign shr = {a, 32'd0} >> amt;
	assign asr = $signed(a) >>> amt;

	always_comb
	begin
		case (ir.shift.func)
			fn_asl:  value = shl[31:0];
			fn_lsr:  value = shr[63:32];
			fn_asr:  value = asr;
			// Rotates fold the spilled half back onto the result
			fn_rol:  value = shl[31:0] | shl[63:32];
			fn_ror:  value = shr[63:32] | shr[31:0];
			default: value = 32'hdeadbeef;
		endcase
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the ALU cluster testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f build.f --top-module tb_alu_cluster \
	-Mdir obj_dir -o sim_alu_cluster > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat build.log
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_alu_cluster > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "test passed" sim.log; then
	exit 0
fi
exit 1
